//--- sources.f
logic/ps2_frame_pkg.sv
logic/ps2_timing_pkg.sv
logic/ps2_input_sync.sv
logic/ps2_bus_timers.sv
logic/ps2_frame_shifter.sv
logic/ps2_link_fsm.sv
logic/ps2_rx_holding.sv
logic/ps2_host_top.sv
verif/ps2_host_tb.sv

//--- verif/ps2_host_cases.txt
# one case per line: operation letter, then the byte in hex
# R receive, T transmit with ack, N transmit without ack, W watchdog then receive
R 1c
R f0
T ff
T ed
R 5a
N 3c
R 00
W 9a
T 00
R ff
N a5
R 81
W 12
T f4

//--- verif/ps2_host_tb.sv
// clk_divide_i is fixed at 8 cycles per tick; cases are read from verif/ps2_host_cases.txt
module ps2_host_tb;
  import ps2_frame_pkg::*;
  import ps2_timing_pkg::*;

  localparam int CLK_HALF      = 20;
  localparam int RESET_CYCLES  = 10;
  // device half bit-period of 40 us at eight cycles per microsecond, plus 0 to 7 jitter
  localparam int HALF_CYCLES   = 320;
  localparam int BIT_CYCLES    = 2 * (HALF_CYCLES + 7);
  localparam int WAIT_LIMIT    = 2000;
  localparam int GAP_MIN       = 16;
  // longer than the 480 cycle inhibit period, so the watchdog must fire
  localparam int WATCHDOG_IDLE = 640;
  localparam int SEL_READY     = 0;
  localparam int SEL_WRITE_ACK = 1;
  localparam int SEL_INHIBIT   = 2;

  logic        clk = 1'b0;
  logic        reset;
  ps2_line_t   ps2_pins;
  ps2_line_t   ps2_drive_low;
  prescale_t   clk_divide;
  ps2_byte_t   scan_code;
  logic        data_ready;
  logic        rx_read;
  ps2_byte_t   tx_byte;
  logic        tx_write;
  logic        tx_write_ack;
  logic        tx_error_no_ack;
  logic        dev_clk;
  logic        dev_data;
  logic        error_seen;
  logic [9:0]  dev_bits;
  logic [31:0] rng_state = 32'ha3e7_3e30;
  int          failures = 0;
  int          limit_cycles = 0;
  logic [7:0]  case_op[$];
  ps2_byte_t   case_byte[$];

  always #CLK_HALF clk = ~clk;

  // each bus line is a wired AND of the device and the host pull-down
  assign ps2_pins = {dev_clk & ~ps2_drive_low.clk, dev_data & ~ps2_drive_low.data};

  ps2_host_top dut_i (
    .clk               (clk),
    .reset             (reset),
    .ps2_i             (ps2_pins),
    .ps2_drive_low_o   (ps2_drive_low),
    .clk_divide_i      (clk_divide),
    .scan_code_o       (scan_code),
    .data_ready_o      (data_ready),
    .rx_read_i         (rx_read),
    .tx_byte_i         (tx_byte),
    .tx_write_i        (tx_write),
    .tx_write_ack_o    (tx_write_ack),
    .tx_error_no_ack_o (tx_error_no_ack)
  );

  // the no-ack flag is short, so it is caught by a sticky monitor
  always @(negedge clk)
  begin
    if (tx_error_no_ack)
      error_seen = 1'b1;
  end

  // --------------------------------------------------------------------------
  // helpers and checks
  // --------------------------------------------------------------------------

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // odd parity bit is set when the byte holds an even number of ones
  function automatic logic odd_parity(input ps2_byte_t value);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++)
      ones += value[i];
    return (ones % 2) == 0;
  endfunction

  // stop, parity, data and start from top to bottom, sent from bit 0 up
  function automatic ps2_frame_t make_frame(input ps2_byte_t value);
    return {1'b1, odd_parity(value), value, 1'b0};
  endfunction

  function automatic int half_period();
    return HALF_CYCLES + int'(next_random() & 32'd7);
  endfunction

  function automatic logic probe(input int sel);
    case (sel)
      SEL_READY:     return data_ready;
      SEL_WRITE_ACK: return tx_write_ack;
      SEL_INHIBIT:   return ps2_drive_low.clk;
      default:       return 1'bx;
    endcase
  endfunction

  task automatic declare_failure();
    failures++;
    $display("ERRORS FOUND");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic compare_byte(input string name, input ps2_byte_t actual,
                              input ps2_byte_t expected);
    if (actual !== expected)
    begin
      $display("MISMATCH at time %0t: %s is %h, expected %h", $time, name, actual, expected);
      declare_failure();
    end
  endtask

  task automatic compare_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected)
    begin
      $display("MISMATCH at time %0t: %s is %b, expected %b", $time, name, actual, expected);
      declare_failure();
    end
  endtask

  task automatic hold_cycles(input int count);
    repeat (count) @(posedge clk);
  endtask

  // samples on falling edges until the selected signal reaches the level
  task automatic wait_level(input int sel, input logic level, input string what);
    int waited;
    waited = 0;
    @(negedge clk);
    while (probe(sel) !== level)
    begin
      if (waited == WAIT_LIMIT)
      begin
        $display("gave up waiting for %s after %0d cycles", what, WAIT_LIMIT);
        declare_failure();
      end
      waited++;
      @(negedge clk);
    end
  endtask

  // --------------------------------------------------------------------------
  // device bus model
  // --------------------------------------------------------------------------

  // data changes in the middle of the high phase, the host samples on the fall
  task automatic device_send(input ps2_frame_t frame, input int nbits);
    int half;
    for (int i = 0; i < nbits; i++)
    begin
      half = half_period();
      @(posedge clk);
      dev_data <= frame[i];
      hold_cycles(half / 2);
      dev_clk <= 1'b0;
      hold_cycles(half);
      dev_clk <= 1'b1;
      hold_cycles(half / 2);
    end
    dev_data <= 1'b1;
  endtask

  // host to device, the device reads each bit just before its rising clock edge
  task automatic device_receive(input logic give_ack);
    int half;
    wait_level(SEL_INHIBIT, 1'b1, "the host to pull the clock low");
    wait_level(SEL_INHIBIT, 1'b0, "the host to release the clock");
    compare_bit("ps2 data line at clock release", ps2_pins.data, 1'b0);
    hold_cycles(half_period());
    for (int i = 0; i < TX_SHIFT_BITS; i++)
    begin
      half = half_period();
      dev_clk <= 1'b0;
      hold_cycles(half - 1);
      @(negedge clk);
      dev_bits[i] = ps2_pins.data;
      @(posedge clk);
      dev_clk <= 1'b1;
      hold_cycles(half / 2);
      // the acknowledge must be on the line before the next falling edge
      if (i == TX_SHIFT_BITS - 1 && give_ack)
        dev_data <= 1'b0;
      hold_cycles(half - half / 2);
    end
    half = half_period();
    dev_clk <= 1'b0;
    hold_cycles(half);
    dev_clk <= 1'b1;
    hold_cycles(half / 2);
    dev_data <= 1'b1;
  endtask

  // --------------------------------------------------------------------------
  // case runners
  // --------------------------------------------------------------------------

  task automatic issue_write(input ps2_byte_t value);
    @(posedge clk);
    tx_byte  <= value;
    tx_write <= 1'b1;
    wait_level(SEL_WRITE_ACK, 1'b1, "tx_write_ack_o");
    @(posedge clk);
    tx_write <= 1'b0;
  endtask

  task automatic run_receive(input ps2_byte_t value);
    device_send(make_frame(value), FRAME_BITS);
    wait_level(SEL_READY, 1'b1, "data_ready_o");
    compare_byte("scan_code_o", scan_code, value);
    // one edge to align, then a read delay of 0 to 5 cycles
    hold_cycles(1 + int'(next_random() % 32'd6));
    rx_read <= 1'b1;
    @(posedge clk);
    rx_read <= 1'b0;
    @(negedge clk);
    compare_bit("data_ready_o after read", data_ready, 1'b0);
  endtask

  task run_transmit(input ps2_byte_t value, input logic give_ack);
    error_seen = 1'b0;
    fork
      issue_write(value);
      device_receive(give_ack);
    join
    compare_bit("device start bit", dev_bits[0], 1'b0);
    compare_byte("device captured byte", dev_bits[8:1], value);
    compare_bit("device parity bit", dev_bits[9], odd_parity(value));
    compare_bit("tx_error_no_ack_o seen", error_seen, !give_ack);
  endtask

  // a partial frame is abandoned by the device and must not spoil the next one
  task automatic run_watchdog(input ps2_byte_t value);
    device_send(make_frame(ps2_byte_t'(next_random())), 4);
    hold_cycles(WATCHDOG_IDLE + half_period());
    @(negedge clk);
    compare_bit("data_ready_o after partial frame", data_ready, 1'b0);
    run_receive(value);
  endtask

  // --------------------------------------------------------------------------
  // main sequence and timeout
  // --------------------------------------------------------------------------

  initial
  begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: the cases did not finish within %0d cycles", limit_cycles);
    declare_failure();
  end

  initial
  begin
    int fd;
    int c;
    int got;
    ps2_byte_t value;
    reset      = 1'b1;
    clk_divide = prescale_t'(8);
    rx_read    = 1'b0;
    tx_byte    = '0;
    tx_write   = 1'b0;
    dev_clk    = 1'b1;
    dev_data   = 1'b1;
    error_seen = 1'b0;
    fd = $fopen("verif/ps2_host_cases.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open the case file verif/ps2_host_cases.txt");
      declare_failure();
    end
    // lines starting with # are skipped, otherwise a letter and a hex byte
    c = $fgetc(fd);
    while (c != -1)
    begin
      if (c == "#")
      begin
        while (c != -1 && c != "\n")
          c = $fgetc(fd);
      end
      else if (c != " " && c != "\n" && c != "\r" && c != "\t")
      begin
        got = $fscanf(fd, "%h", value);
        if (got != 1)
        begin
          $display("the case file has an operation without a byte");
          declare_failure();
        end
        case_op.push_back(c[7:0]);
        case_byte.push_back(value);
      end
      c = $fgetc(fd);
    end
    $fclose(fd);
    if (case_op.size() == 0)
    begin
      $display("the case file holds no cases");
      declare_failure();
    end
    limit_cycles = RESET_CYCLES + case_op.size() * 30 * BIT_CYCLES;

    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    compare_bit("ps2_drive_low_o.clk after reset", ps2_drive_low.clk, 1'b0);
    compare_bit("ps2_drive_low_o.data after reset", ps2_drive_low.data, 1'b0);
    compare_bit("data_ready_o after reset", data_ready, 1'b0);
    compare_bit("tx_error_no_ack_o after reset", tx_error_no_ack, 1'b0);
    compare_bit("tx_write_ack_o after reset", tx_write_ack, 1'b0);

    for (int i = 0; i < case_op.size(); i++)
    begin
      // random idle gap, the error flag must be clear once the bus is idle
      hold_cycles(GAP_MIN + int'(next_random() % 32'd48));
      @(negedge clk);
      compare_bit("tx_error_no_ack_o while idle", tx_error_no_ack, 1'b0);
      case (case_op[i])
        "R": run_receive(case_byte[i]);
        "T": run_transmit(case_byte[i], 1'b1);
        "N": run_transmit(case_byte[i], 1'b0);
        "W": run_watchdog(case_byte[i]);
        default:
        begin
          $display("unknown operation %c in the case file", case_op[i]);
          declare_failure();
        end
      endcase
    end

    if (failures == 0)
    begin
      $display("NO ERRORS");
      $finish;
    end
    else
      declare_failure();
  end

endmodule

//--- logic/ps2_host_top.sv
// ps2 host top; pads are external and clk_divide_i gives clk cycles per microsecond
module ps2_host_top (
  input  logic                      clk,
  input  logic                      reset,
  input  ps2_frame_pkg::ps2_line_t  ps2_i,
  output ps2_frame_pkg::ps2_line_t  ps2_drive_low_o,
  input  ps2_timing_pkg::prescale_t clk_divide_i,
  output ps2_frame_pkg::ps2_byte_t  scan_code_o,
  output logic                      data_ready_o,
  input  logic                      rx_read_i,
  input  ps2_frame_pkg::ps2_byte_t  tx_byte_i,
  input  logic                      tx_write_i,
  output logic                      tx_write_ack_o,
  output logic                      tx_error_no_ack_o
);
  import ps2_frame_pkg::*;

  ps2_line_t ps2_s;
  ps2_byte_t rx_byte;
  logic      inhibit_en;
  logic      settle_en;
  logic      inhibit_done;
  logic      settle_done;
  logic      shift;
  logic      count_clear;
  logic      tx_bit;
  logic      rx_frame_done;
  logic      tx_bits_done;

  ps2_input_sync input_sync_i (
    .clk     (clk),
    .reset   (reset),
    .ps2_i   (ps2_i),
    .ps2_s_o (ps2_s)
  );

  ps2_bus_timers bus_timers_i (
    .clk            (clk),
    .reset          (reset),
    .clk_divide_i   (clk_divide_i),
    .inhibit_en_i   (inhibit_en),
    .settle_en_i    (settle_en),
    .inhibit_done_o (inhibit_done),
    .settle_done_o  (settle_done)
  );

  // the write acknowledge is also the load strobe for the shift register
  ps2_frame_shifter frame_shifter_i (
    .clk             (clk),
    .reset           (reset),
    .load_i          (tx_write_ack_o),
    .tx_byte_i       (tx_byte_i),
    .shift_i         (shift),
    .data_bit_i      (ps2_s.data),
    .count_clear_i   (count_clear),
    .tx_bit_o        (tx_bit),
    .rx_byte_o       (rx_byte),
    .rx_frame_done_o (rx_frame_done),
    .tx_bits_done_o  (tx_bits_done)
  );

  ps2_link_fsm link_fsm_i (
    .clk               (clk),
    .reset             (reset),
    .ps2_s_i           (ps2_s),
    .tx_write_i        (tx_write_i),
    .inhibit_done_i    (inhibit_done),
    .settle_done_i     (settle_done),
    .tx_bits_done_i    (tx_bits_done),
    .tx_bit_i          (tx_bit),
    .tx_write_ack_o    (tx_write_ack_o),
    .shift_o           (shift),
    .count_clear_o     (count_clear),
    .inhibit_en_o      (inhibit_en),
    .settle_en_o       (settle_en),
    .drive_low_o       (ps2_drive_low_o),
    .tx_error_no_ack_o (tx_error_no_ack_o)
  );

  ps2_rx_holding rx_holding_i (
    .clk             (clk),
    .reset           (reset),
    .rx_frame_done_i (rx_frame_done),
    .rx_byte_i       (rx_byte),
    .rx_read_i       (rx_read_i),
    .scan_code_o     (scan_code_o),
    .data_ready_o    (data_ready_o)
  );

endmodule

//--- logic/ps2_rx_holding.sv
// a frame arriving before the read overwrites the held scan code
module ps2_rx_holding (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     rx_frame_done_i,
  input  ps2_frame_pkg::ps2_byte_t rx_byte_i,
  input  logic                     rx_read_i,
  output ps2_frame_pkg::ps2_byte_t scan_code_o,
  output logic                     data_ready_o
);

  typedef enum logic {
    hold_waiting,
    hold_ready
  } hold_state_t;

  hold_state_t state;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      scan_code_o <= '0;
    else if (rx_frame_done_i)
      scan_code_o <= rx_byte_i;
  end

  // a new frame wins over a read in the same cycle so no code is lost
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      state <= hold_waiting;
    else if (rx_frame_done_i)
      state <= hold_ready;
    else if (rx_read_i)
      state <= hold_waiting;
  end

  assign data_ready_o = (state == hold_ready);

endmodule

//--- logic/ps2_link_fsm.sv
// outputs are drive-low enables for an external open-drain pad with pull-up
module ps2_link_fsm (
  input  logic                     clk,
  input  logic                     reset,
  input  ps2_frame_pkg::ps2_line_t ps2_s_i,
  input  logic                     tx_write_i,
  input  logic                     inhibit_done_i,
  input  logic                     settle_done_i,
  input  logic                     tx_bits_done_i,
  input  logic                     tx_bit_i,
  output logic                     tx_write_ack_o,
  output logic                     shift_o,
  output logic                     count_clear_o,
  output logic                     inhibit_en_o,
  output logic                     settle_en_o,
  output ps2_frame_pkg::ps2_line_t drive_low_o,
  output logic                     tx_error_no_ack_o
);
  import ps2_frame_pkg::*;

  link_state_t state;
  link_state_t state_next;
  logic        rx_idle;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      state <= link_rx_clk_h;
    else
      state <= state_next;
  end

  // a write is only taken while the link follows the device clock
  assign rx_idle = (state == link_rx_clk_h) || (state == link_rx_clk_l);
  assign tx_write_ack_o = tx_write_i && rx_idle;

  // receive samples on the falling edge, transmit advances on the rising edge
  assign shift_o = (state == link_rx_fall_mark) || (state == link_tx_rise_mark);

  // the watchdog drops a partial frame once the clock has idled high long enough
  assign count_clear_o = (state == link_tx_wait_ack)
                      || ((state == link_rx_clk_h) && ps2_s_i.clk && inhibit_done_i);

  // --------------------------------------------------------------------------
  // next state and outputs
  // --------------------------------------------------------------------------

  always_comb
  begin
    state_next        = state;
    inhibit_en_o      = 1'b0;
    settle_en_o       = 1'b0;
    drive_low_o       = '{clk: 1'b0, data: 1'b0};
    tx_error_no_ack_o = 1'b0;
    case (state)
      // receive side, the inhibit timer runs as the inactivity watchdog
      link_rx_clk_h:
      begin
        inhibit_en_o = 1'b1;
        if (tx_write_i)
          state_next = link_tx_reset_timer;
        else if (!ps2_s_i.clk)
          state_next = link_rx_fall_mark;
      end
      link_rx_fall_mark:
        state_next = link_rx_clk_l;
      link_rx_clk_l:
      begin
        inhibit_en_o = 1'b1;
        if (tx_write_i)
          state_next = link_tx_reset_timer;
        else if (ps2_s_i.clk)
          state_next = link_rx_rise_mark;
      end
      link_rx_rise_mark:
        state_next = link_rx_clk_h;
      // one cycle with the enable low restarts the inhibit timer
      link_tx_reset_timer:
        state_next = link_tx_force_clk_l;
      link_tx_force_clk_l:
      begin
        inhibit_en_o    = 1'b1;
        drive_low_o.clk = 1'b1;
        if (inhibit_done_i)
          state_next = link_tx_first_wait;
      end
      // start bit held low until the device starts clocking
      // the settle time hides the lag of our own clock release
      link_tx_first_wait:
      begin
        settle_en_o      = 1'b1;
        drive_low_o.data = 1'b1;
        if (!ps2_s_i.clk && settle_done_i)
          state_next = link_tx_clk_l;
      end
      link_tx_clk_l:
      begin
        drive_low_o.data = !tx_bit_i;
        if (ps2_s_i.clk)
          state_next = link_tx_wait_clk_h;
      end
      link_tx_wait_clk_h:
      begin
        settle_en_o      = 1'b1;
        drive_low_o.data = !tx_bit_i;
        if (ps2_s_i.clk && settle_done_i)
          state_next = link_tx_rise_mark;
      end
      link_tx_rise_mark:
      begin
        drive_low_o.data = !tx_bit_i;
        state_next       = link_tx_clk_h;
      end
      link_tx_clk_h:
      begin
        drive_low_o.data = !tx_bit_i;
        if (tx_bits_done_i)
          state_next = link_tx_wait_ack;
        else if (!ps2_s_i.clk)
          state_next = link_tx_clk_l;
      end
      // data released for the stop bit, the device answers while clock is low
      link_tx_wait_ack:
      begin
        if (!ps2_s_i.clk && ps2_s_i.data)
          state_next = link_tx_error_no_ack;
        else if (!ps2_s_i.clk && !ps2_s_i.data)
          state_next = link_tx_done_recovery;
      end
      link_tx_done_recovery:
      begin
        if (ps2_s_i.clk && ps2_s_i.data)
          state_next = link_rx_clk_h;
      end
      link_tx_error_no_ack:
      begin
        tx_error_no_ack_o = 1'b1;
        if (ps2_s_i.clk && ps2_s_i.data)
          state_next = link_rx_clk_h;
      end
      link_spare:
        state_next = link_rx_clk_h;
      default:
        state_next = link_rx_clk_h;
    endcase
  end

endmodule

//--- logic/ps2_frame_shifter.sv
// one shift register serves both directions; receive parity is not checked
module ps2_frame_shifter (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     load_i,
  input  ps2_frame_pkg::ps2_byte_t tx_byte_i,
  input  logic                     shift_i,
  input  logic                     data_bit_i,
  input  logic                     count_clear_i,
  output logic                     tx_bit_o,
  output ps2_frame_pkg::ps2_byte_t rx_byte_o,
  output logic                     rx_frame_done_o,
  output logic                     tx_bits_done_o
);
  import ps2_frame_pkg::*;

  ps2_frame_t frame_q;
  bit_count_t bit_count;
  logic       tx_parity;

  // odd parity, set when the byte holds an even number of ones
  assign tx_parity = ~^tx_byte_i;

  // bits move towards bit 0, which is the one on the wire when transmitting
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      frame_q <= '0;
    else if (load_i)
      frame_q <= {1'b1, tx_parity, tx_byte_i, 1'b0};
    else if (shift_i)
      frame_q <= {data_bit_i, frame_q[FRAME_BITS-1:1]};
  end

  // a completed receive frame clears the count the cycle after it is seen
  // a new transmit load also starts the count from zero
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      bit_count <= '0;
    else if (count_clear_i || rx_frame_done_o || load_i)
      bit_count <= '0;
    else if (shift_i)
      bit_count <= bit_count + bit_count_t'(1);
  end

  assign rx_frame_done_o = (bit_count == bit_count_t'(FRAME_BITS));
  assign tx_bits_done_o  = (bit_count == bit_count_t'(TX_SHIFT_BITS));

  // after a full receive frame the data byte sits just above the start bit
  assign tx_bit_o  = frame_q[0];
  assign rx_byte_o = frame_q[8:1];

endmodule

//--- logic/ps2_bus_timers.sv
// clk_divide_i must be at least 1; a done output holds until its enable falls
module ps2_bus_timers (
  input  logic                      clk,
  input  logic                      reset,
  input  ps2_timing_pkg::prescale_t clk_divide_i,
  input  logic                      inhibit_en_i,
  input  logic                      settle_en_i,
  output logic                      inhibit_done_o,
  output logic                      settle_done_o
);
  import ps2_timing_pkg::*;

  prescale_t      prescale_count;
  logic           timer_active;
  logic           tick;
  inhibit_count_t inhibit_count;
  settle_count_t  settle_count;

  // --------------------------------------------------------------------------
  // prescaler
  // --------------------------------------------------------------------------

  // the prescaler restarts whenever no timer is running, so the first tick
  // comes one full period after an enable rises
  assign timer_active = inhibit_en_i | settle_en_i;
  assign tick = timer_active && (prescale_count == clk_divide_i - prescale_t'(1));

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      prescale_count <= '0;
    else if (!timer_active || tick)
      prescale_count <= '0;
    else
      prescale_count <= prescale_count + prescale_t'(1);
  end

  // --------------------------------------------------------------------------
  // tick counters, both saturate at their terminal count
  // --------------------------------------------------------------------------

  // the inhibit counter doubles as the receive watchdog while the bus idles
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      inhibit_count <= '0;
    else if (!inhibit_en_i)
      inhibit_count <= '0;
    else if (tick && !inhibit_done_o)
      inhibit_count <= inhibit_count + inhibit_count_t'(1);
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      settle_count <= '0;
    else if (!settle_en_i)
      settle_count <= '0;
    else if (tick && !settle_done_o)
      settle_count <= settle_count + settle_count_t'(1);
  end

  assign inhibit_done_o = (inhibit_count == INHIBIT_TICKS);
  assign settle_done_o  = (settle_count == SETTLE_TICKS);

endmodule

//--- logic/ps2_input_sync.sv
// both lines reset to the idle high level and reach the core two clk cycles late
module ps2_input_sync (
  input  logic                     clk,
  input  logic                     reset,
  input  ps2_frame_pkg::ps2_line_t ps2_i,
  output ps2_frame_pkg::ps2_line_t ps2_s_o
);
  import ps2_frame_pkg::*;

  // first stage may go metastable, only the second stage is used
  ps2_line_t ps2_meta;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      ps2_meta <= '{clk: 1'b1, data: 1'b1};
      ps2_s_o  <= '{clk: 1'b1, data: 1'b1};
    end
    else
    begin
      ps2_meta <= ps2_i;
      ps2_s_o  <= ps2_meta;
    end
  end

endmodule

//--- logic/ps2_timing_pkg.sv
// tick counts assume one prescaler tick per microsecond of bus time
package ps2_timing_pkg;

  // runtime divide value, clk cycles per one microsecond tick
  typedef logic [15:0] prescale_t;

  // counter types wide enough to hold their terminal tick count
  typedef logic [5:0] inhibit_count_t;
  typedef logic [2:0] settle_count_t;

  // clock inhibit before a transmit, also the receive inactivity watchdog
  localparam inhibit_count_t INHIBIT_TICKS = 6'd60;

  // debounce time after a clock edge that the host may have caused itself
  localparam settle_count_t SETTLE_TICKS = 3'd5;

endpackage

//--- logic/ps2_frame_pkg.sv
// frame layout and link states for a ps2 host; parity is odd and bits travel lsb first
package ps2_frame_pkg;

  // -------------------------------------------------------------------------
  // frame geometry
  // -------------------------------------------------------------------------

  // start bit, eight data bits, odd parity and stop bit
  localparam int FRAME_BITS = 11;

  // bits the host drives itself, the stop bit is left to the pull-up
  localparam int TX_SHIFT_BITS = 10;

  typedef logic [7:0]            ps2_byte_t;
  typedef logic [FRAME_BITS-1:0] ps2_frame_t;
  typedef logic [3:0]            bit_count_t;

  // one bit per bus line, used for pin levels as well as drive-low enables
  typedef struct packed {
    logic clk;
    logic data;
  } ps2_line_t;

  // -------------------------------------------------------------------------
  // link state machine
  // -------------------------------------------------------------------------

  // link_spare is never entered on purpose, it only returns to idle
  typedef enum logic [3:0] {
    link_rx_clk_h, link_rx_clk_l, link_rx_fall_mark, link_rx_rise_mark,
    link_tx_reset_timer, link_tx_force_clk_l, link_tx_first_wait, link_tx_wait_clk_h,
    link_tx_rise_mark, link_tx_clk_h, link_tx_clk_l, link_tx_wait_ack,
    link_tx_done_recovery, link_tx_error_no_ack, link_spare
  } link_state_t;

endpackage
